/* vp_cart_pkg.sv */
/*
 * Shared constants for the cartridge path
 * Bus widths, image sizes that select the bank layout,
 * and the download indices accepted by the loader
 */

package vp_cart_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	// Download and ROM data byte
	localparam int DATA_W = 8;

	// 16 KiB cartridge ROM
	localparam int ROM_AW = 14;

	// Console CPU cartridge address
	localparam int CPU_AW = 12;

	// Download port address, only the low ROM_AW bits reach the ROM
	localparam int LOAD_AW = 25;

	// Download index
	localparam int IDX_W = 8;

	// Image size counter
	localparam int SIZE_W = 16;

	////////////////////////////////////////
	// Download indices
	////////////////////////////////////////

	// Regular cartridge image
	localparam logic [IDX_W-1:0] IDX_CART = 8'd1;

	// XROM image, linear mapping
	localparam logic [IDX_W-1:0] IDX_XROM = 8'd2;

	////////////////////////////////////////
	// Image sizes with their own layout
	////////////////////////////////////////

	// Two 2K banks
	localparam logic [SIZE_W-1:0] SIZE_4K = 16'd4096;

	// Four 2K banks
	localparam logic [SIZE_W-1:0] SIZE_8K = 16'd8192;

	// Four 3K banks packed in 4K slots
	localparam logic [SIZE_W-1:0] SIZE_16K = 16'd16384;

endpackage

/* vp_cart_loader.sv */
/*
 * Cartridge download loader
 * Start edge detect, image size counter, XROM flag,
 * and the qualified ROM write port
 */

`timescale 1ns/1ps

module vp_cart_loader (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_active_i,
	input  logic [vp_cart_pkg::IDX_W-1:0]     load_index_i,
	input  logic                              load_wr_i,
	input  logic [vp_cart_pkg::LOAD_AW-1:0]   load_addr_i,
	input  logic [vp_cart_pkg::DATA_W-1:0]    load_data_i,
	output logic [vp_cart_pkg::SIZE_W-1:0]    image_size_o,
	output logic                              xrom_mode_o,
	output logic                              rom_wr_en_o,
	output logic [vp_cart_pkg::ROM_AW-1:0]    rom_wr_addr_o,
	output logic [vp_cart_pkg::DATA_W-1:0]    rom_wr_data_o
);

	logic                            load_active_q;
	logic                            cart_index;
	logic                            start_load;
	logic                            wr_accept;
	logic [vp_cart_pkg::SIZE_W-1:0]  image_size_q;
	logic                            xrom_mode_q;

	// Only cartridge and XROM images go to this ROM
	assign cart_index = (load_index_i == vp_cart_pkg::IDX_CART) ||
		(load_index_i == vp_cart_pkg::IDX_XROM);

	// First cycle of a cartridge download window
	assign start_load = load_active_i & ~load_active_q & cart_index;
	assign wr_accept  = load_active_i & load_wr_i & cart_index;

	////////////////////////////////////////
	// Size counter and mode flag
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			load_active_q <= 1'b0;
			image_size_q  <= '0;
			xrom_mode_q   <= 1'b0;
		end else begin
			load_active_q <= load_active_i;
			if (start_load) begin
				// A strobe in the very first cycle still counts
				image_size_q <= {{(vp_cart_pkg::SIZE_W-1){1'b0}}, wr_accept};
				xrom_mode_q  <= (load_index_i == vp_cart_pkg::IDX_XROM);
			end else if (wr_accept) begin
				image_size_q <= image_size_q + {{(vp_cart_pkg::SIZE_W-1){1'b0}}, 1'b1};
			end
		end
	end

	assign image_size_o = image_size_q;
	assign xrom_mode_o  = xrom_mode_q;

	// Write goes straight to the ROM in the strobe cycle
	assign rom_wr_en_o   = wr_accept;
	assign rom_wr_addr_o = load_addr_i[vp_cart_pkg::ROM_AW-1:0];
	assign rom_wr_data_o = load_data_i;

	// Finished images fit the 16K ROM
	a_size_in_rom: assert property (@(posedge clk_sys) disable iff (reset)
		!load_active_i |-> (image_size_o <= vp_cart_pkg::SIZE_16K));

endmodule

/* vp_cart_bank_map.sv */
/*
 * Cartridge bank mapper
 * CPU address and bank lines to ROM address by image size
 * and XROM mode, plus the read enable rule
 */

`timescale 1ns/1ps

module vp_cart_bank_map (
	input  logic [vp_cart_pkg::SIZE_W-1:0]  image_size_i,
	input  logic                            xrom_mode_i,
	input  logic                            load_active_i,
	input  logic [vp_cart_pkg::CPU_AW-1:0]  cpu_addr_i,
	input  logic                            bank0_i,
	input  logic                            bank1_i,
	input  logic                            cs_n_i,
	input  logic                            psen_n_i,
	output logic [vp_cart_pkg::ROM_AW-1:0]  rom_rd_addr_o,
	output logic                            rom_rd_en_o
);

	logic cart_rd;
	logic xrom_rd;

	////////////////////////////////////////
	// Address layout
	////////////////////////////////////////

	// A10 is dropped in the 2K bank layouts
	always_comb begin
		if (xrom_mode_i) begin
			rom_rd_addr_o = {2'b00, cpu_addr_i[11:0]};
		end else begin
			case (image_size_i)
				vp_cart_pkg::SIZE_4K: begin
					rom_rd_addr_o = {2'b00, bank0_i, cpu_addr_i[11], cpu_addr_i[9:0]};
				end
				vp_cart_pkg::SIZE_8K: begin
					rom_rd_addr_o = {1'b0, bank1_i, bank0_i, cpu_addr_i[11], cpu_addr_i[9:0]};
				end
				vp_cart_pkg::SIZE_16K: begin
					// 12K games, full 4K slot per bank
					rom_rd_addr_o = {bank1_i, bank0_i, cpu_addr_i[11:0]};
				end
				default: begin
					// 2K and odd sizes, bank lines ignored
					rom_rd_addr_o = {3'b000, cpu_addr_i[11], cpu_addr_i[9:0]};
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Read enable
	////////////////////////////////////////

	// Program store read
	assign cart_rd = ~psen_n_i;

	// XROM is read as data, but not while CS and BS0 are both high
	assign xrom_rd = psen_n_i & ~(cs_n_i & bank0_i);

	// No reads while the ROM is being loaded
	assign rom_rd_en_o = ~load_active_i & (xrom_mode_i ? xrom_rd : cart_rd);

endmodule

/* vp_cart_rom.sv */
/*
 * Cartridge ROM, 16 KiB of bytes
 * Download write port and registered read port
 */

`timescale 1ns/1ps

module vp_cart_rom (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            wr_en_i,
	input  logic [vp_cart_pkg::ROM_AW-1:0]  wr_addr_i,
	input  logic [vp_cart_pkg::DATA_W-1:0]  wr_data_i,
	input  logic                            rd_en_i,
	input  logic [vp_cart_pkg::ROM_AW-1:0]  rd_addr_i,
	output logic [vp_cart_pkg::DATA_W-1:0]  rd_data_o
);

	logic [vp_cart_pkg::DATA_W-1:0] mem [0:(1 << vp_cart_pkg::ROM_AW)-1];
	logic [vp_cart_pkg::DATA_W-1:0] rd_data_q;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////

	// Data shows one cycle after the read, held in between
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rd_data_q <= '0;
		end else if (rd_en_i) begin
			rd_data_q <= mem[rd_addr_i];
		end
	end

	assign rd_data_o = rd_data_q;

	// Loader and mapper never share the single port
	a_no_rd_wr: assert property (@(posedge clk_sys) disable iff (reset)
		!(wr_en_i && rd_en_i));

endmodule

/* vp_cart.sv */
/*
 * Cartridge path top level
 * Loader, bank mapper and ROM
 */

`timescale 1ns/1ps

module vp_cart (
	input  logic                              clk_sys,
	input  logic                              reset,
	// Download port
	input  logic                              load_active_i,
	input  logic [vp_cart_pkg::IDX_W-1:0]     load_index_i,
	input  logic                              load_wr_i,
	input  logic [vp_cart_pkg::LOAD_AW-1:0]   load_addr_i,
	input  logic [vp_cart_pkg::DATA_W-1:0]    load_data_i,
	// Console CPU side
	input  logic [vp_cart_pkg::CPU_AW-1:0]    cpu_addr_i,
	input  logic                              bank0_i,
	input  logic                              bank1_i,
	input  logic                              cs_n_i,
	input  logic                              psen_n_i,
	output logic [vp_cart_pkg::DATA_W-1:0]    rd_data_o
);

	logic [vp_cart_pkg::SIZE_W-1:0]  image_size;
	logic                            xrom_mode;
	logic                            rom_wr_en;
	logic [vp_cart_pkg::ROM_AW-1:0]  rom_wr_addr;
	logic [vp_cart_pkg::DATA_W-1:0]  rom_wr_data;
	logic                            rom_rd_en;
	logic [vp_cart_pkg::ROM_AW-1:0]  rom_rd_addr;

	vp_cart_loader i_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active_i (load_active_i),
		.load_index_i  (load_index_i),
		.load_wr_i     (load_wr_i),
		.load_addr_i   (load_addr_i),
		.load_data_i   (load_data_i),
		.image_size_o  (image_size),
		.xrom_mode_o   (xrom_mode),
		.rom_wr_en_o   (rom_wr_en),
		.rom_wr_addr_o (rom_wr_addr),
		.rom_wr_data_o (rom_wr_data)
	);

	vp_cart_bank_map i_bank_map (
		.image_size_i  (image_size),
		.xrom_mode_i   (xrom_mode),
		.load_active_i (load_active_i),
		.cpu_addr_i    (cpu_addr_i),
		.bank0_i       (bank0_i),
		.bank1_i       (bank1_i),
		.cs_n_i        (cs_n_i),
		.psen_n_i      (psen_n_i),
		.rom_rd_addr_o (rom_rd_addr),
		.rom_rd_en_o   (rom_rd_en)
	);

	vp_cart_rom i_rom (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wr_en_i   (rom_wr_en),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (rom_wr_data),
		.rd_en_i   (rom_rd_en),
		.rd_addr_i (rom_rd_addr),
		.rd_data_o (rd_data_o)
	);

endmodule

/* vp_cart_tb.sv */
/*
 * Testbench for the cartridge path
 * Stimulus table, LFSR image bytes, shadow ROM model,
 * data compare task and watchdog
 */

`timescale 1ns/1ps

module vp_cart_tb;

	logic                              clk_sys;
	logic                              reset;
	logic                              load_active_i;
	logic [vp_cart_pkg::IDX_W-1:0]     load_index_i;
	logic                              load_wr_i;
	logic [vp_cart_pkg::LOAD_AW-1:0]   load_addr_i;
	logic [vp_cart_pkg::DATA_W-1:0]    load_data_i;
	logic [vp_cart_pkg::CPU_AW-1:0]    cpu_addr_i;
	logic                              bank0_i;
	logic                              bank1_i;
	logic                              cs_n_i;
	logic                              psen_n_i;
	logic [vp_cart_pkg::DATA_W-1:0]    rd_data_o;

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	// 2K cart, 4K cart, 8K cart, 16K cart, XROM, ignored index
	logic [vp_cart_pkg::IDX_W-1:0] test_idx [6] = '{8'd1, 8'd1, 8'd1, 8'd1, 8'd2, 8'd3};
	int test_len [6] = '{2048, 4096, 8192, 16384, 2048, 256};

	// Each read is {cs_n, psen_n, bank1, bank0, cpu_addr[11:0]}
	logic [15:0] test_rd [6][4] = '{
		'{16'hB000, 16'h85FF, 16'h9C23, 16'hA7FF},
		'{16'h8123, 16'h9123, 16'h9FFF, 16'hA800},
		'{16'h8000, 16'h94AB, 16'hA955, 16'hBFFF},
		'{16'h9000, 16'hA7FF, 16'hBFFF, 16'h8400},
		'{16'h5123, 16'hCC00, 16'hD456, 16'h0456},
		'{16'h4010, 16'h40FF, 16'hCE00, 16'h7080}
	};

	// Shadow ROM and expected loader state
	logic [vp_cart_pkg::DATA_W-1:0] shadow [0:(1 << vp_cart_pkg::ROM_AW)-1];
	logic [vp_cart_pkg::SIZE_W-1:0] exp_size;
	logic                           exp_xrom;
	logic [vp_cart_pkg::DATA_W-1:0] exp_data;
	logic [15:0]                    lfsr_state;
	int                             errors;
	int                             checks;
	int                             test_errors;

	vp_cart i_dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active_i (load_active_i),
		.load_index_i  (load_index_i),
		.load_wr_i     (load_wr_i),
		.load_addr_i   (load_addr_i),
		.load_data_i   (load_data_i),
		.cpu_addr_i    (cpu_addr_i),
		.bank0_i       (bank0_i),
		.bank1_i       (bank1_i),
		.cs_n_i        (cs_n_i),
		.psen_n_i      (psen_n_i),
		.rd_data_o     (rd_data_o)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Models
	////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[0] ^ s[2] ^ s[3] ^ s[5];
		return {fb, s[15:1]};
	endfunction

	task automatic next_byte(output logic [vp_cart_pkg::DATA_W-1:0] b);
		for (int k = 0; k < vp_cart_pkg::DATA_W; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[vp_cart_pkg::DATA_W-2:0], lfsr_state[15]};
		end
	endtask

	// ROM offset the console reaches for one access
	function automatic logic [vp_cart_pkg::ROM_AW-1:0] rom_addr_of(input logic xrom,
		input logic [vp_cart_pkg::SIZE_W-1:0] size, input logic [15:0] rd);
		int low2k;
		int bank;
		int r;
		// 2K window, A11 selects the upper 1K, A10 unused
		low2k = int'(rd[9:0]) + 1024 * int'(rd[11]);
		bank = 2 * int'(rd[13]) + int'(rd[12]);
		if (xrom)
			r = int'(rd[11:0]);
		else if (size == vp_cart_pkg::SIZE_4K)
			r = 2048 * int'(rd[12]) + low2k;
		else if (size == vp_cart_pkg::SIZE_8K)
			r = 2048 * bank + low2k;
		else if (size == vp_cart_pkg::SIZE_16K)
			r = 4096 * bank + int'(rd[11:0]);
		else
			r = low2k;
		return r[vp_cart_pkg::ROM_AW-1:0];
	endfunction

	function automatic logic read_allowed(input logic xrom, input logic [15:0] rd);
		if (xrom)
			return rd[14] && !(rd[15] && rd[12]);
		return !rd[14];
	endfunction

	task automatic check_data(input string name, input logic [vp_cart_pkg::DATA_W-1:0] got,
		input logic [vp_cart_pkg::DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	////////////////////////////////////////
	// Drivers
	////////////////////////////////////////

	// CS and BS0 high with PSEN high blocks reads in both modes
	task automatic go_idle();
		cpu_addr_i = '0;
		bank0_i    = 1'b1;
		bank1_i    = 1'b0;
		cs_n_i     = 1'b1;
		psen_n_i   = 1'b1;
	endtask

	task automatic download(input logic [vp_cart_pkg::IDX_W-1:0] idx, input int len);
		logic [vp_cart_pkg::DATA_W-1:0] b;
		logic                           to_rom;
		to_rom = (idx == vp_cart_pkg::IDX_CART) || (idx == vp_cart_pkg::IDX_XROM);
		load_active_i = 1'b1;
		load_index_i  = idx;
		for (int i = 0; i < len; i++) begin
			next_byte(b);
			load_wr_i   = 1'b1;
			load_addr_i = i[vp_cart_pkg::LOAD_AW-1:0];
			load_data_i = b;
			if (to_rom)
				shadow[i[vp_cart_pkg::ROM_AW-1:0]] = b;
			@(posedge clk_sys);
			#1;
		end
		load_wr_i     = 1'b0;
		load_active_i = 1'b0;
		@(posedge clk_sys);
		#1;
		if (to_rom) begin
			exp_size = len[vp_cart_pkg::SIZE_W-1:0];
			exp_xrom = (idx == vp_cart_pkg::IDX_XROM);
		end
	endtask

	// Data is due one cycle after the access, held when no read
	task automatic cpu_read(input logic [15:0] rd);
		cpu_addr_i = rd[11:0];
		bank0_i    = rd[12];
		bank1_i    = rd[13];
		psen_n_i   = rd[14];
		cs_n_i     = rd[15];
		if (read_allowed(exp_xrom, rd))
			exp_data = shadow[rom_addr_of(exp_xrom, exp_size, rd)];
		@(posedge clk_sys);
		#1;
		check_data("rd_data_o", rd_data_o, exp_data);
	endtask

	initial begin
		string verdict;
		reset         = 1'b1;
		load_active_i = 1'b0;
		load_index_i  = '0;
		load_wr_i     = 1'b0;
		load_addr_i   = '0;
		load_data_i   = '0;
		go_idle();
		errors     = 0;
		checks     = 0;
		lfsr_state = 16'd44394;
		exp_size   = '0;
		exp_xrom   = 1'b0;
		exp_data   = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (int t = 0; t < $size(test_len); t++) begin
			test_errors = 0;
			download(test_idx[t], test_len[t]);
			for (int r = 0; r < $size(test_rd, 2); r++)
				cpu_read(test_rd[t][r]);
			go_idle();
			if (test_errors == 0)
				verdict = "ok";
			else
				verdict = "failed";
			$display("Test %0d: index %0d, %0d bytes, %0d errors, %s", t + 1, test_idx[t],
				test_len[t], test_errors, verdict);
		end
		$display("%0d tests, %0d checks, %0d errors", $size(test_len), checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		int limit;
		limit = 5;
		for (int t = 0; t < $size(test_len); t++)
			limit += 2 * (test_len[t] + $size(test_rd, 2));
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d clock cycles", limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* vp_cart.f */
vp_cart_pkg.sv
vp_cart_loader.sv
vp_cart_bank_map.sv
vp_cart_rom.sv
vp_cart.sv
vp_cart_tb.sv

/* Makefile */
# Verilator simulation of the cartridge path

SIM := obj_dir/vp_cart_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f vp_cart.f --top-module vp_cart_tb -o vp_cart_sim
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
